// File: logic/trace_params.svh
// shared constants for the trace unit, included wherever the stamp width or opcodes are needed
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// cycle stamp width, the counter wraps
`define TRACE_STAMP_W 16

// rv32i major opcodes
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011
`define OPC_SYSTEM 7'b1110011

`endif

// File: logic/trace_pkg.sv
// types shared by the trace unit blocks, import where the record or decode types are used
`include "trace_params.svh"

package trace_pkg;

  //////////////////////////////
  // instruction class
  //////////////////////////////

  // numbering is fixed, the testdata refers to it
  typedef enum logic [3:0] {
    cls_invalid = 4'd0,
    cls_nop     = 4'd1,
    cls_lui     = 4'd2,
    cls_auipc   = 4'd3,
    cls_jal     = 4'd4,
    cls_jalr    = 4'd5,
    cls_branch  = 4'd6,
    cls_load    = 4'd7,
    cls_store   = 4'd8,
    cls_op_imm  = 4'd9,
    cls_op      = 4'd10,
    cls_muldiv  = 4'd11,
    cls_system  = 4'd12
  } instr_class_e;

  // data-bus tracker FSM
  typedef enum logic [1:0] {
    trk_idle,
    trk_wait_gnt,
    trk_wait_data
  } trk_state_e;

  //////////////////////////////
  // record structs
  //////////////////////////////

  // classifier result
  typedef struct packed {
    instr_class_e instr_class;
    logic [4:0]   rd;
    logic         writes_rd;
  } decode_t;

  // one data-memory access
  typedef struct packed {
    logic        present;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
  } mem_acc_t;

  // full trace record, stamp taken at issue
  typedef struct packed {
    logic [`TRACE_STAMP_W-1:0] stamp;
    logic [31:0]               pc;
    logic [31:0]               instr;
    instr_class_e              instr_class;
    logic [4:0]                rd;
    logic                      rd_written;
    logic [31:0]               rd_value;
    mem_acc_t                  mem;
  } trace_rec_t;

endpackage

// File: logic/instr_classifier.sv
// combinational instruction classifier, feeds the trace assembler in the issue cycle
`timescale 1ns/1ns
`include "trace_params.svh"

module instr_classifier (
  input  logic [31:0]       instr,
  output trace_pkg::decode_t decode
);

  import trace_pkg::*;

  logic [6:0]   opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  instr_class_e cls;
  logic         wr;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  //////////////////////////////
  // class decode
  //////////////////////////////
  always_comb
  begin
    cls = cls_invalid;
    case (opcode)
      `OPC_LUI:    cls = cls_lui;
      `OPC_AUIPC:  cls = cls_auipc;
      `OPC_JAL:    cls = cls_jal;
      `OPC_JALR:   cls = (funct3 == 3'b000) ? cls_jalr : cls_invalid;
      // funct3 010 and 011 are not branch conditions
      `OPC_BRANCH: cls = (funct3[2:1] == 2'b01) ? cls_invalid : cls_branch;
      `OPC_LOAD:
      begin
        // lb lh lw lbu lhu only, reg-reg and post-inc forms fall out here
        if (funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111)
          cls = cls_invalid;
        else
          cls = cls_load;
      end
      `OPC_STORE:  cls = (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010) ?
                         cls_store : cls_invalid;
      `OPC_OP_IMM: cls = (instr == 32'h0000_0013) ? cls_nop : cls_op_imm;
      `OPC_OP:
      begin
        if (funct7 == 7'b0000001)
          cls = cls_muldiv;
        else if (funct7 == 7'b0000000 || funct7 == 7'b0100000)
          cls = cls_op;
        else
          cls = cls_invalid;
      end
      `OPC_SYSTEM: cls = cls_system;
      default:     cls = cls_invalid;
    endcase
  end

  // which classes write a destination register
  always_comb
  begin
    case (cls)
      cls_lui, cls_auipc, cls_jal, cls_jalr, cls_load,
      cls_op_imm, cls_op, cls_muldiv, cls_system: wr = 1'b1;
      default:                                    wr = 1'b0;
    endcase
  end

  // rd field only reported when it is a real destination
  assign decode.instr_class = cls;
  assign decode.writes_rd   = wr;
  assign decode.rd          = wr ? instr[11:7] : 5'd0;

endmodule

// File: logic/mem_access_tracker.sv
// follows one data-bus access from request to data valid and hands the result to the assembler
`timescale 1ns/1ns

module mem_access_tracker (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                data_gnt,
  input  logic                data_we,
  input  logic [31:0]         data_addr,
  input  logic [31:0]         data_wdata,
  input  logic                data_valid,
  input  logic [31:0]         load_data,
  output logic                mem_done,
  output trace_pkg::mem_acc_t mem_acc
);

  import trace_pkg::*;

  trk_state_e state_q;
  trk_state_e state_d;
  logic       gnt_fire;
  logic       data_fire;
  logic       done_q;
  mem_acc_t   acc_q;

  // grant can already be there on the start cycle
  assign gnt_fire  = data_gnt && ((state_q == trk_idle && start) || state_q == trk_wait_gnt);
  assign data_fire = (state_q == trk_wait_data) && data_valid;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      trk_idle:
      begin
        if (start)
          state_d = data_gnt ? trk_wait_data : trk_wait_gnt;
      end
      trk_wait_gnt:
      begin
        if (data_gnt)
          state_d = trk_wait_data;
      end
      trk_wait_data:
      begin
        if (data_valid)
          state_d = trk_idle;
      end
      default: state_d = trk_idle;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= trk_idle;
      done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      done_q  <= data_fire;
    end
  end

  //////////////////////////////
  // access capture
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (gnt_fire)
    begin
      acc_q.present <= 1'b1;
      acc_q.we      <= data_we;
      acc_q.addr    <= data_addr;
      acc_q.wdata   <= data_wdata;
      acc_q.rdata   <= 32'd0;
    end
    // stores keep rdata at zero
    if (data_fire && !acc_q.we)
      acc_q.rdata <= load_data;
  end

  assign mem_done = done_q;
  assign mem_acc  = acc_q;

endmodule

// File: logic/trace_assembler.sv
// builds trace records from decode, writeback and memory results, emits them as valid pulses
`timescale 1ns/1ns
`include "trace_params.svh"

module trace_assembler (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  logic                  data_req,
  input  logic [31:0]           pc,
  input  logic [31:0]           instr,
  input  trace_pkg::decode_t    decode,
  input  logic                  reg_we,
  input  logic [4:0]            reg_addr,
  input  logic [31:0]           reg_wdata,
  input  logic                  mem_done,
  input  trace_pkg::mem_acc_t   mem_acc,
  output logic                  trace_valid,
  output trace_pkg::trace_rec_t trace_rec
);

  import trace_pkg::*;

  logic [`TRACE_STAMP_W-1:0] stamp_q;
  logic                      rd_wr;
  logic                      wb_hit;
  trace_rec_t                rec_new;
  trace_rec_t                out_q;
  logic                      out_valid_q;
  trace_rec_t                park_q;
  trace_rec_t                park_merged;

  // free running, wraps
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      stamp_q <= '0;
    else
      stamp_q <= stamp_q + 1'b1;
  end

  //////////////////////////////
  // record at issue
  //////////////////////////////
  assign rd_wr  = decode.writes_rd && (decode.rd != 5'd0);
  assign wb_hit = rd_wr && reg_we && (reg_addr == decode.rd);

  always_comb
  begin
    rec_new             = '0;
    rec_new.stamp       = stamp_q;
    rec_new.pc          = pc;
    rec_new.instr       = instr;
    rec_new.instr_class = decode.instr_class;
    rec_new.rd          = decode.rd;
    rec_new.rd_written  = rd_wr;
    rec_new.rd_value    = wb_hit ? reg_wdata : 32'd0;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      out_valid_q <= 1'b0;
    else
      out_valid_q <= issue && !data_req;
  end

  // record payload, direct or parked for memory
  always_ff @(posedge clk)
  begin
    if (issue && !data_req)
      out_q <= rec_new;
    if (issue && data_req)
      park_q <= rec_new;
  end

  //////////////////////////////
  // memory merge and output
  //////////////////////////////
  always_comb
  begin
    park_merged     = park_q;
    park_merged.mem = mem_acc;
    // load result replaces the writeback value
    if (!mem_acc.we && park_q.rd_written)
      park_merged.rd_value = mem_acc.rdata;
  end

  assign trace_valid = out_valid_q || mem_done;
  assign trace_rec   = mem_done ? park_merged : out_q;

endmodule

// File: logic/trace_unit_top.sv
// retire-trace unit top, connects classifier, bus tracker and record assembler to the core
`timescale 1ns/1ns

module trace_unit_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  logic [31:0]           pc,
  input  logic [31:0]           instr,
  input  logic                  ex_reg_we,
  input  logic [4:0]            ex_reg_addr,
  input  logic [31:0]           ex_reg_wdata,
  input  logic                  ex_data_req,
  input  logic                  ex_data_gnt,
  input  logic                  ex_data_we,
  input  logic [31:0]           ex_data_addr,
  input  logic [31:0]           ex_data_wdata,
  input  logic                  data_valid_lsu,
  input  logic [31:0]           lsu_reg_wdata,
  output logic                  trace_valid,
  output trace_pkg::trace_rec_t trace_rec
);

  import trace_pkg::*;

  decode_t  decode;
  logic     mem_start;
  logic     mem_done;
  mem_acc_t mem_acc;

  // tracker only starts for memory instructions
  assign mem_start = issue && ex_data_req;

  instr_classifier u_instr_classifier (
    .instr  (instr),
    .decode (decode)
  );

  mem_access_tracker u_mem_access_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (mem_start),
    .data_gnt   (ex_data_gnt),
    .data_we    (ex_data_we),
    .data_addr  (ex_data_addr),
    .data_wdata (ex_data_wdata),
    .data_valid (data_valid_lsu),
    .load_data  (lsu_reg_wdata),
    .mem_done   (mem_done),
    .mem_acc    (mem_acc)
  );

  trace_assembler u_trace_assembler (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue       (issue),
    .data_req    (ex_data_req),
    .pc          (pc),
    .instr       (instr),
    .decode      (decode),
    .reg_we      (ex_reg_we),
    .reg_addr    (ex_reg_addr),
    .reg_wdata   (ex_reg_wdata),
    .mem_done    (mem_done),
    .mem_acc     (mem_acc),
    .trace_valid (trace_valid),
    .trace_rec   (trace_rec)
  );

endmodule

// File: testbench/tb_clock_gen.sv
// clock and reset source for the trace unit testbench, 100 ns period and two reset cycles
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // release just after an edge, in step with the stimulus
  initial
  begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #10 rst_n = 1'b1;
  end

endmodule

// File: testbench/tb_trace_unit.sv
// testbench for the trace unit, replays the testdata lines and checks every emitted record
`timescale 1ns/1ns
`include "trace_params.svh"

module tb_trace_unit;

  import trace_pkg::*;

  localparam int drive_delay = 10;
  localparam int max_lines   = 32;

  // one testdata line, every field padded to whole hex digits
  typedef struct packed {
    logic [7:0]  gap;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [3:0]  wb_we;
    logic [7:0]  wb_addr;
    logic [31:0] wb_data;
    logic [3:0]  data_req;
    logic [7:0]  gnt_dly;
    logic [7:0]  data_dly;
    logic [31:0] mem_addr;
    logic [3:0]  mem_we;
    logic [31:0] mem_wdata;
    logic [31:0] load_data;
    logic [3:0]  exp_class;
    logic [3:0]  exp_written;
    logic [31:0] exp_value;
  } stim_line_t;

  logic        clk;
  logic        rst_n;
  logic        issue;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        ex_reg_we;
  logic [4:0]  ex_reg_addr;
  logic [31:0] ex_reg_wdata;
  logic        ex_data_req;
  logic        ex_data_gnt;
  logic        ex_data_we;
  logic [31:0] ex_data_addr;
  logic [31:0] ex_data_wdata;
  logic        data_valid_lsu;
  logic [31:0] lsu_reg_wdata;
  logic        trace_valid;
  trace_rec_t  trace_rec;

  logic [275:0] lines [0:max_lines-1];
  trace_rec_t   exp_q[$];
  int           due_q[$];
  int           edge_count    = 0;
  int           cycle_count   = 0;
  int           timeout_limit = 0;
  int           line_count    = 0;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  trace_unit_top u_trace_unit_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue          (issue),
    .pc             (pc),
    .instr          (instr),
    .ex_reg_we      (ex_reg_we),
    .ex_reg_addr    (ex_reg_addr),
    .ex_reg_wdata   (ex_reg_wdata),
    .ex_data_req    (ex_data_req),
    .ex_data_gnt    (ex_data_gnt),
    .ex_data_we     (ex_data_we),
    .ex_data_addr   (ex_data_addr),
    .ex_data_wdata  (ex_data_wdata),
    .data_valid_lsu (data_valid_lsu),
    .lsu_reg_wdata  (lsu_reg_wdata),
    .trace_valid    (trace_valid),
    .trace_rec      (trace_rec)
  );

  //////////////////////////////
  // reporting and checks
  //////////////////////////////
  task automatic fail_now(input string note);
    $display("%s", note);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    assert (got_val === exp_val)
      else fail_now($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp_val, got_val));
  endtask

  task automatic compare_record(input trace_rec_t exp_rec, input trace_rec_t got_rec);
    check_field("stamp", 32'(exp_rec.stamp), 32'(got_rec.stamp));
    check_field("pc", exp_rec.pc, got_rec.pc);
    check_field("instr", exp_rec.instr, got_rec.instr);
    check_field("instr_class", 32'(exp_rec.instr_class), 32'(got_rec.instr_class));
    check_field("rd", 32'(exp_rec.rd), 32'(got_rec.rd));
    check_field("rd_written", 32'(exp_rec.rd_written), 32'(got_rec.rd_written));
    check_field("rd_value", exp_rec.rd_value, got_rec.rd_value);
    check_field("mem.present", 32'(exp_rec.mem.present), 32'(got_rec.mem.present));
    check_field("mem.we", 32'(exp_rec.mem.we), 32'(got_rec.mem.we));
    check_field("mem.addr", exp_rec.mem.addr, got_rec.mem.addr);
    check_field("mem.wdata", exp_rec.mem.wdata, got_rec.mem.wdata);
    check_field("mem.rdata", exp_rec.mem.rdata, got_rec.mem.rdata);
  endtask

  // stamp is the number of edges since reset release at the issue edge
  function automatic trace_rec_t expected_record(input stim_line_t ln, input int count);
    trace_rec_t rec;
    rec             = '0;
    rec.stamp       = count[`TRACE_STAMP_W-1:0];
    rec.pc          = ln.pc;
    rec.instr       = ln.instr;
    rec.instr_class = instr_class_e'(ln.exp_class);
    // rd only shows for a real destination
    rec.rd          = ln.exp_written[0] ? ln.instr[11:7] : 5'd0;
    rec.rd_written  = ln.exp_written[0];
    rec.rd_value    = ln.exp_value;
    if (ln.data_req[0])
    begin
      rec.mem.present = 1'b1;
      rec.mem.we      = ln.mem_we[0];
      rec.mem.addr    = ln.mem_addr;
      rec.mem.wdata   = ln.mem_wdata;
      // stores bring back no read data
      rec.mem.rdata   = ln.mem_we[0] ? 32'd0 : ln.load_data;
    end
    return rec;
  endfunction

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic step_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic drive_idle();
    issue          = 1'b0;
    pc             = 32'd0;
    instr          = 32'd0;
    ex_reg_we      = 1'b0;
    ex_reg_addr    = 5'd0;
    ex_reg_wdata   = 32'd0;
    ex_data_req    = 1'b0;
    ex_data_gnt    = 1'b0;
    ex_data_we     = 1'b0;
    ex_data_addr   = 32'd0;
    ex_data_wdata  = 32'd0;
    data_valid_lsu = 1'b0;
    lsu_reg_wdata  = 32'd0;
  endtask

  task automatic run_line(input stim_line_t ln);
    int         k;
    int         dly;
    trace_rec_t rec;
    for (k = 0; k < int'(ln.gap); k++)
      step_cycle();
    rec          = expected_record(ln, edge_count);
    issue        = 1'b1;
    pc           = ln.pc;
    instr        = ln.instr;
    ex_reg_we    = ln.wb_we[0];
    ex_reg_addr  = ln.wb_addr[4:0];
    ex_reg_wdata = ln.wb_data;
    ex_data_req  = ln.data_req[0];
    if (!ln.data_req[0])
    begin
      exp_q.push_back(rec);
      due_q.push_back(edge_count + 1);
      step_cycle();
      drive_idle();
    end
    else
    begin
      ex_data_gnt   = (ln.gnt_dly == 8'd0);
      ex_data_we    = ln.mem_we[0];
      ex_data_addr  = ln.mem_addr;
      ex_data_wdata = ln.mem_wdata;
      step_cycle();
      issue     = 1'b0;
      ex_reg_we = 1'b0;
      for (k = 1; k <= int'(ln.gnt_dly); k++)
      begin
        ex_data_gnt = (k == int'(ln.gnt_dly));
        step_cycle();
      end
      ex_data_gnt = 1'b0;
      ex_data_req = 1'b0;
      // data valid never in the grant cycle
      dly = (ln.data_dly == 8'd0) ? 1 : int'(ln.data_dly);
      for (k = 1; k < dly; k++)
        step_cycle();
      data_valid_lsu = 1'b1;
      lsu_reg_wdata  = ln.load_data;
      exp_q.push_back(rec);
      due_q.push_back(edge_count + 1);
      step_cycle();
      drive_idle();
    end
  endtask

  //////////////////////////////
  // edge count, monitor, timeout
  //////////////////////////////
  always @(posedge clk)
  begin
    if (rst_n)
      edge_count <= edge_count + 1;
  end

  // outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (trace_valid)
    begin
      assert (due_q.size() != 0)
        else fail_now("trace_valid pulsed while no record was expected");
      if (due_q.size() != 0)
      begin
        assert (due_q[0] == edge_count)
          else fail_now($sformatf("record for pc 0x%h came in cycle %0d instead of cycle %0d",
                                  exp_q[0].pc, edge_count, due_q[0]));
        compare_record(exp_q[0], trace_rec);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
    else if (due_q.size() != 0)
    begin
      assert (due_q[0] > edge_count)
        else fail_now($sformatf("record for pc 0x%h did not appear in cycle %0d",
                                exp_q[0].pc, due_q[0]));
    end
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (timeout_limit != 0 && cycle_count >= timeout_limit)
      fail_now($sformatf("timeout after %0d cycles, the test did not finish", cycle_count));
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial
  begin
    stim_line_t ln;
    int         n;
    int         total;
    drive_idle();
    for (n = 0; n < max_lines; n++)
      lines[n] = '0;
    $readmemh("testbench/trace_testdata.txt", lines);
    // list ends at the first zero instr word
    total = 20;
    for (n = 0; n < max_lines; n++)
    begin
      ln = lines[n];
      if (ln.instr != 32'd0 && line_count == n)
      begin
        line_count = line_count + 1;
        total = total + int'(ln.gap) + int'(ln.gnt_dly) + int'(ln.data_dly) + 3;
      end
    end
    timeout_limit = total;
    assert (line_count != 0)
      else fail_now("no lines could be read from the testdata file");
    wait (rst_n === 1'b1);
    for (n = 0; n < line_count; n++)
      run_line(lines[n]);
    repeat (3) step_cycle();
    if (exp_q.size() == 0)
    begin
      $display("No errors");
      $finish;
    end
    else
      fail_now($sformatf("%0d records still missing at the end of the run", exp_q.size()));
  end

endmodule

// File: files.f
+incdir+logic
logic/trace_pkg.sv
logic/instr_classifier.sv
logic/mem_access_tracker.sv
logic/trace_assembler.sv
logic/trace_unit_top.sv
testbench/tb_clock_gen.sv
testbench/tb_trace_unit.sv

// File: Makefile
# Verilator build and run for the trace unit testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_unit
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ns
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up as its own line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/trace_testdata.txt
// gap_pc_instr_wbwe_wbaddr_wbdata_req_gntdly_datadly_maddr_mwe_mwdata_ldata_class_written_value
// all fields hex, a line with a zero instr word ends the list
03_00000100_123452B7_1_05_12345000_0_00_00_00000000_0_00000000_00000000_2_1_12345000
00_00000104_00128333_1_06_00001111_0_00_00_00000000_0_00000000_00000000_A_1_00001111
00_00000108_01030393_1_07_00001121_0_00_00_00000000_0_00000000_00000000_9_1_00001121
00_0000010C_FFF3C413_1_08_FFFFEEDE_0_00_00_00000000_0_00000000_00000000_9_1_FFFFEEDE
00_00000110_008000EF_1_01_00000114_0_00_00_00000000_0_00000000_00000000_4_1_00000114
00_00000118_028384B3_1_09_00000042_0_00_00_00000000_0_00000000_00000000_B_1_00000042
02_0000011C_00500513_1_0B_DEADBEEF_0_00_00_00000000_0_00000000_00000000_9_1_00000000
00_00000120_00A505B3_0_0B_12345678_0_00_00_00000000_0_00000000_00000000_A_1_00000000
00_00000124_00128013_1_00_00000006_0_00_00_00000000_0_00000000_00000000_9_0_00000000
00_00000128_00000013_0_00_00000000_0_00_00_00000000_0_00000000_00000000_1_0_00000000
01_0000012C_0042A603_0_00_00000000_1_02_02_12345004_0_00000000_CAFEF00D_7_1_CAFEF00D
00_00000130_0082A423_0_00_00000000_1_00_01_12345008_1_FFFFEEDE_55AA55AA_8_0_00000000
00_00000134_00628863_0_00_00000000_0_00_00_00000000_0_00000000_00000000_6_0_00000000
00_00000144_B00026F3_1_0D_00000057_0_00_00_00000000_0_00000000_00000000_C_1_00000057
00_00000148_1234500B_1_05_00000001_0_00_00_00000000_0_00000000_00000000_0_0_00000000
00_0000014C_0082B423_0_00_00000000_0_00_00_00000000_0_00000000_00000000_0_0_00000000
00_00000150_00000073_0_00_00000000_0_00_00_00000000_0_00000000_00000000_C_0_00000000
00_00000154_00064703_1_0E_11111111_1_00_01_CAFEF00D_0_00000000_000000A5_7_1_000000A5
